// File: common/pmp_pkg.sv
package pmp_pkg;

  // Region and register counts
  localparam int unsigned PMP_NUM_REGIONS  = 16;
  localparam int unsigned PMP_NUM_CFG_REGS = 4;
  localparam int unsigned PMP_CFG_PER_WORD = 4;
  localparam int unsigned PMP_GRANULARITY  = 2;

  localparam int unsigned PMP_REGION_IDX_W = $clog2(PMP_NUM_REGIONS);
  localparam int unsigned PMP_CFG_IDX_W    = $clog2(PMP_NUM_CFG_REGS);

  // pmpaddr read masks for G=2
  localparam logic [31:0] PMP_ADDR_NAPOT_ONES = 32'((1 << (PMP_GRANULARITY - 1)) - 1);
  localparam logic [31:0] PMP_ADDR_TOR_ZEROS  = 32'((1 << PMP_GRANULARITY) - 1);

  // mseccfg bit positions, MMWP at bit 1 reads as zero
  localparam int unsigned MSECCFG_MML_BIT = 0;
  localparam int unsigned MSECCFG_RLB_BIT = 2;

  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  typedef struct packed {
    logic       lock;
    logic [1:0] zero0;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmp_cfg_t;

  // One pmpcfg CSR, seen as a word or as its entry bytes
  typedef union packed {
    logic [31:0]                          raw;
    pmp_cfg_t [PMP_CFG_PER_WORD-1:0]      cfg;
  } pmpcfg_word_u;

  typedef struct packed {
    logic rlb;
    logic mml;
  } mseccfg_t;

  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'd0,
    PMP_ACC_WRITE = 2'd1,
    PMP_ACC_EXEC  = 2'd2
  } pmp_acc_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [5:0] {
    EXC_INSTR_ACC_FAULT = 6'd1,
    EXC_LOAD_ACC_FAULT  = 6'd5,
    EXC_STORE_ACC_FAULT = 6'd7
  } exc_cause_e;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    pmp_acc_e    acc;
    priv_e       priv;
  } pmp_req_t;

  typedef struct packed {
    logic       valid;
    logic       allowed;
    exc_cause_e cause;
  } pmp_rsp_t;

  // addr entries hold physical address bits 33:2
  typedef struct packed {
    pmp_cfg_t [PMP_NUM_REGIONS-1:0]          cfg;
    logic     [PMP_NUM_REGIONS-1:0][31:0]    addr;
    mseccfg_t                                mseccfg;
  } pmp_state_t;

endpackage

// File: common/csr_map_pkg.sv
package csr_map_pkg;

  // CSR numbers, carried in APB paddr[13:2]
  localparam logic [11:0] CSR_PMPCFG0  = 12'h3A0;
  localparam logic [11:0] CSR_PMPADDR0 = 12'h3B0;
  localparam logic [11:0] CSR_MSECCFG  = 12'h747;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [2:0]  pprot;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    CSR_KIND_CFG     = 2'd0,
    CSR_KIND_ADDR    = 2'd1,
    CSR_KIND_MSECCFG = 2'd2
  } csr_kind_e;

  // Accepted register write, index relative to the first CSR of its kind
  typedef struct packed {
    logic        strobe;
    csr_kind_e   kind;
    logic [5:0]  idx;
    logic [31:0] data;
  } csr_wr_t;

endpackage

// File: pmp_csr/pmp_cfg_legalize.sv
`timescale 1ns/1ps

module pmp_cfg_legalize
  import pmp_pkg::*;
(
  input  pmpcfg_word_u prev_i,
  input  pmpcfg_word_u attempt_i,
  input  mseccfg_t     mseccfg_i,
  output pmpcfg_word_u legal_o
);

  always_comb begin
    pmp_cfg_t prev;
    pmp_cfg_t att;
    pmp_cfg_t res;
    logic     locked_exec;
    for (int b = 0; b < PMP_CFG_PER_WORD; b++) begin
      prev = prev_i.cfg[b];
      att  = attempt_i.cfg[b];
      res  = att;

      // W without R is reserved unless MML
      if (!mseccfg_i.mml && att.write && !att.read) begin
        res.exec  = prev.exec;
        res.write = prev.write;
        res.read  = prev.read;
      end

      // NA4 not selectable for G >= 1
      if ((PMP_GRANULARITY >= 1) && (att.mode == PMP_MODE_NA4)) begin
        res.mode = prev.mode;
      end

      if (prev.lock && !mseccfg_i.rlb) begin
        res = prev;
      end

      // Locked executable patterns refused under MML
      locked_exec = {att.lock, att.read, att.write, att.exec}
                    inside {4'b1001, 4'b1010, 4'b1011, 4'b1101};
      if (mseccfg_i.mml && !mseccfg_i.rlb && locked_exec) begin
        res = prev;
      end

      res.zero0     = '0;
      legal_o.cfg[b] = res;
    end
  end

endmodule

// File: pmp_csr/pmp_csr_apb.sv
`timescale 1ns/1ps

module pmp_csr_apb
  import pmp_pkg::*;
  import csr_map_pkg::*;
(
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  input  pmp_state_t state_i,
  output csr_wr_t    csr_wr_o
);

  logic [11:0]                 csr_num;
  logic [11:0]                 cfg_off;
  logic [11:0]                 addr_off;
  logic                        access;
  logic                        cfg_hit;
  logic                        addr_hit;
  logic                        msec_hit;
  logic                        mapped;
  logic                        read_only;
  logic                        priv_ok;
  logic                        err;
  logic [PMP_CFG_IDX_W-1:0]    cfg_sel;
  logic [PMP_REGION_IDX_W-1:0] addr_sel;
  csr_kind_e                   kind;
  logic [5:0]                  idx;
  pmpcfg_word_u                cfg_word;
  pmp_cfg_t                    addr_cfg;
  logic [31:0]                 rdata;

  assign csr_num  = apb_req_i.paddr[13:2];
  assign cfg_off  = csr_num - CSR_PMPCFG0;
  assign addr_off = csr_num - CSR_PMPADDR0;

  // Only implemented entries are mapped
  assign cfg_hit  = cfg_off < 12'(PMP_NUM_CFG_REGS);
  assign addr_hit = addr_off < 12'(PMP_NUM_REGIONS);
  assign msec_hit = csr_num == CSR_MSECCFG;
  assign mapped   = cfg_hit | addr_hit | msec_hit;

  // RISC-V convention, CSR number bits 11:10 of 11 mark read-only
  assign read_only = csr_num[11:10] == 2'b11;
  assign priv_ok   = apb_req_i.pprot[0];

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign err    = !priv_ok || !mapped || (apb_req_i.pwrite && read_only);

  always_comb begin
    kind = CSR_KIND_CFG;
    idx  = cfg_off[5:0];
    if (addr_hit) begin
      kind = CSR_KIND_ADDR;
      idx  = addr_off[5:0];
    end else if (msec_hit) begin
      kind = CSR_KIND_MSECCFG;
      idx  = '0;
    end
  end

  assign cfg_sel  = idx[PMP_CFG_IDX_W-1:0];
  assign addr_sel = idx[PMP_REGION_IDX_W-1:0];

  assign cfg_word.cfg = state_i.cfg[PMP_CFG_PER_WORD * cfg_sel +: PMP_CFG_PER_WORD];
  assign addr_cfg     = state_i.cfg[addr_sel];

  // Read view; stored pmpaddr bits stay untouched
  always_comb begin
    rdata = '0;
    case (kind)
      CSR_KIND_CFG: begin
        rdata = cfg_word.raw;
      end
      CSR_KIND_ADDR: begin
        if (addr_cfg.mode[1]) begin
          rdata = state_i.addr[addr_sel] | PMP_ADDR_NAPOT_ONES;
        end else begin
          rdata = state_i.addr[addr_sel] & ~PMP_ADDR_TOR_ZEROS;
        end
      end
      default: begin
        rdata[MSECCFG_MML_BIT] = state_i.mseccfg.mml;
        rdata[MSECCFG_RLB_BIT] = state_i.mseccfg.rlb;
      end
    endcase
  end

  // No wait states
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access & err;
  assign apb_rsp_o.prdata  = (access && !err && !apb_req_i.pwrite) ? rdata : '0;

  assign csr_wr_o.strobe = access & apb_req_i.pwrite & ~err;
  assign csr_wr_o.kind   = kind;
  assign csr_wr_o.idx    = idx;
  assign csr_wr_o.data   = apb_req_i.pwdata;

endmodule

// File: pmp_csr/pmp_csr_regs.sv
`timescale 1ns/1ps

module pmp_csr_regs
  import pmp_pkg::*;
  import csr_map_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  csr_wr_t    csr_wr_i,
  output pmp_state_t state_o
);

  pmp_state_t                 state_q;
  pmpcfg_word_u               cfg_prev;
  pmpcfg_word_u               cfg_attempt;
  pmpcfg_word_u               cfg_legal;
  logic [PMP_CFG_IDX_W-1:0]   cfg_sel;
  logic                       cfg_wr;
  logic                       msec_wr;
  logic [PMP_NUM_REGIONS-1:0] lock_vec;
  logic [PMP_NUM_REGIONS-1:0] tor_lock_vec;
  logic [PMP_NUM_REGIONS-1:0] tor_guard;
  logic [PMP_NUM_REGIONS-1:0] addr_wr_en;
  logic                       any_locked;
  logic                       rlb_set_ok;

  assign cfg_wr  = csr_wr_i.strobe && (csr_wr_i.kind == CSR_KIND_CFG);
  assign msec_wr = csr_wr_i.strobe && (csr_wr_i.kind == CSR_KIND_MSECCFG);
  assign cfg_sel = csr_wr_i.idx[PMP_CFG_IDX_W-1:0];

  assign cfg_prev.cfg    = state_q.cfg[PMP_CFG_PER_WORD * cfg_sel +: PMP_CFG_PER_WORD];
  assign cfg_attempt.raw = csr_wr_i.data;

  pmp_cfg_legalize legalize_i (
    .prev_i    (cfg_prev),
    .attempt_i (cfg_attempt),
    .mseccfg_i (state_q.mseccfg),
    .legal_o   (cfg_legal)
  );

  always_comb begin
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      lock_vec[i]     = state_q.cfg[i].lock;
      tor_lock_vec[i] = state_q.cfg[i].lock && (state_q.cfg[i].mode == PMP_MODE_TOR);
    end
  end

  // Entry i is guarded by a locked TOR entry at i+1
  assign tor_guard  = tor_lock_vec >> 1;
  assign any_locked = |lock_vec;

  always_comb begin
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      addr_wr_en[i] = csr_wr_i.strobe && (csr_wr_i.kind == CSR_KIND_ADDR) &&
                      (csr_wr_i.idx == 6'(i));
      if (!state_q.mseccfg.rlb && (lock_vec[i] || tor_guard[i])) begin
        addr_wr_en[i] = 1'b0;
      end
    end
  end

  // RLB can be raised only while nothing is locked, or kept once set
  assign rlb_set_ok = state_q.mseccfg.rlb | ~any_locked;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      if (cfg_wr) begin
        state_q.cfg[PMP_CFG_PER_WORD * cfg_sel +: PMP_CFG_PER_WORD] <= cfg_legal.cfg;
      end
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        if (addr_wr_en[i]) begin
          state_q.addr[i] <= csr_wr_i.data;
        end
      end
      if (msec_wr) begin
        // MML is sticky until reset
        state_q.mseccfg.mml <= state_q.mseccfg.mml | csr_wr_i.data[MSECCFG_MML_BIT];
        state_q.mseccfg.rlb <= csr_wr_i.data[MSECCFG_RLB_BIT] & rlb_set_ok;
      end
    end
  end

  assign state_o = state_q;

endmodule

// File: src/pmp_access_check.sv
`timescale 1ns/1ps

module pmp_access_check
  import pmp_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  pmp_state_t state_i,
  input  pmp_req_t   req_i,
  output pmp_rsp_t   rsp_o
);

  logic [33:0]                req_addr;
  logic [PMP_NUM_REGIONS-1:0] region_hit;
  logic                       match_found;
  pmp_cfg_t                   match_cfg;
  logic                       perm;
  logic                       allowed_d;
  exc_cause_e                 cause_d;
  logic                       rsp_valid_q;
  logic                       allowed_q;
  exc_cause_e                 cause_q;

  assign req_addr = {2'b00, req_i.addr};

  always_comb begin : region_match
    logic [33:0] lo;
    logic [33:0] hi;
    logic [31:0] care;
    // Region 0 TOR starts at address zero
    lo = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      hi   = {state_i.addr[i], 2'b00};
      // Trailing ones plus the next zero are the NAPOT size bits
      care = ~(state_i.addr[i] ^ (state_i.addr[i] + 32'd1));
      case (state_i.cfg[i].mode)
        PMP_MODE_TOR: begin
          region_hit[i] = (req_addr >= lo) && (req_addr < hi);
        end
        PMP_MODE_NAPOT: begin
          region_hit[i] = ((req_addr[33:2] ^ state_i.addr[i]) & care) == '0;
        end
        default: begin
          region_hit[i] = 1'b0;
        end
      endcase
      lo = hi;
    end
  end

  // Lowest index wins
  always_comb begin : region_select
    match_found = 1'b0;
    match_cfg   = '0;
    for (int i = PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        match_found = 1'b1;
        match_cfg   = state_i.cfg[i];
      end
    end
  end

  // Cause is only meaningful on a denial
  always_comb begin : decide
    case (req_i.acc)
      PMP_ACC_EXEC: begin
        perm    = match_cfg.exec;
        cause_d = EXC_INSTR_ACC_FAULT;
      end
      PMP_ACC_WRITE: begin
        perm    = match_cfg.write;
        cause_d = EXC_STORE_ACC_FAULT;
      end
      default: begin
        perm    = match_cfg.read;
        cause_d = EXC_LOAD_ACC_FAULT;
      end
    endcase
    if (req_i.priv == PRIV_M) begin
      allowed_d = !match_found || !match_cfg.lock || perm;
    end else begin
      allowed_d = match_found && perm;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      allowed_q <= allowed_d;
      cause_q   <= cause_d;
    end
  end

  assign rsp_o.valid   = rsp_valid_q;
  assign rsp_o.allowed = allowed_q;
  assign rsp_o.cause   = cause_q;

endmodule

// File: src/pmp_unit.sv
`timescale 1ns/1ps

module pmp_unit
  import pmp_pkg::*;
  import csr_map_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  pmp_req_t pmp_req_i,
  output pmp_rsp_t pmp_rsp_o
);

  pmp_state_t state;
  csr_wr_t    csr_wr;

  // Register access path
  pmp_csr_apb csr_apb_i (
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .state_i   (state),
    .csr_wr_o  (csr_wr)
  );

  pmp_csr_regs csr_regs_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .csr_wr_i (csr_wr),
    .state_o  (state)
  );

  // Access check sees the stored state one cycle after a write
  pmp_access_check access_check_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .state_i (state),
    .req_i   (pmp_req_i),
    .rsp_o   (pmp_rsp_o)
  );

endmodule

// File: tb/pmp_unit_checker.sv
`timescale 1ns/1ps

module pmp_unit_checker
  import pmp_pkg::*;
  import csr_map_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input csr_wr_t    csr_wr_i,
  input pmp_state_t state_i
);

  logic any_locked;

  always_comb begin
    any_locked = 1'b0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      any_locked = any_locked | state_i.cfg[i].lock;
    end
  end

  // MML stays set until reset
  mml_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i.mseccfg.mml |=> state_i.mseccfg.mml)
    else $error("mseccfg.mml cleared while out of reset");

  rlb_blocked_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!state_i.mseccfg.rlb && any_locked) |=> !state_i.mseccfg.rlb)
    else $error("mseccfg.rlb set while an entry is locked");

  // State moves only on an accepted write
  quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !csr_wr_i.strobe |=> $stable(state_i))
    else $error("PMP state changed without a write strobe");

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : g_entry
    cfg_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_i.cfg[i].zero0 == 2'b00) && (state_i.cfg[i].mode != PMP_MODE_NA4))
      else $error("entry %0d holds an illegal cfg byte", i);

    lock_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_i.cfg[i].lock && !state_i.mseccfg.rlb) |=> $stable(state_i.cfg[i]))
      else $error("locked entry %0d cfg changed", i);
  end

endmodule

bind pmp_csr_regs pmp_unit_checker regs_checker_i (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .csr_wr_i (csr_wr_i),
  .state_i  (state_o)
);

// File: tb/pmp_unit_tb.sv
`timescale 1ns/1ps

module pmp_unit_tb
  import pmp_pkg::*;
  import csr_map_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 20;

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  pmp_req_t    pmp_req;
  pmp_rsp_t    pmp_rsp;
  logic        error_seen;
  logic        last_req_valid;
  logic [31:0] rng_state;

  // Mirror of the CSR state
  logic [7:0]  m_cfg  [PMP_NUM_REGIONS];
  logic [31:0] m_addr [PMP_NUM_REGIONS];
  logic        m_mml;
  logic        m_rlb;

  // Expected APB {pslverr, prdata} and PMP {allowed, cause}
  logic [32:0] apb_exp_q [$];
  logic [6:0]  rsp_exp_q [$];

  pmp_unit dut_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .pmp_req_i (pmp_req),
    .pmp_rsp_o (pmp_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_stop(input string msg);
    error_seen = 1'b1;
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic is_cfg(input logic [11:0] csr);
    return (csr >= CSR_PMPCFG0) && (csr < CSR_PMPCFG0 + 12'(PMP_NUM_CFG_REGS));
  endfunction

  function automatic logic is_addr(input logic [11:0] csr);
    return (csr >= CSR_PMPADDR0) && (csr < CSR_PMPADDR0 + 12'(PMP_NUM_REGIONS));
  endfunction

  // Byte layout L, 2 zero bits, A[1:0], X, W, R
  function automatic logic [7:0] ref_legalize(input logic [7:0] prev, input logic [7:0] att,
                                              input logic mml, input logic rlb);
    logic [7:0] res;
    logic [3:0] lrwx;
    res = att;
    if (!mml && att[1] && !att[0]) begin
      res[2:0] = prev[2:0];
    end
    if (att[4:3] == 2'b10) begin
      res[4:3] = prev[4:3];
    end
    if (prev[7] && !rlb) begin
      res = prev;
    end
    lrwx = {att[7], att[0], att[1], att[2]};
    if (mml && !rlb && (lrwx inside {4'b1001, 4'b1010, 4'b1011, 4'b1101})) begin
      res = prev;
    end
    res[6:5] = 2'b00;
    return res;
  endfunction

  function automatic logic [31:0] ref_read(input logic [11:0] csr);
    int idx;
    if (is_cfg(csr)) begin
      idx = 4 * int'(csr - CSR_PMPCFG0);
      return {m_cfg[idx+3], m_cfg[idx+2], m_cfg[idx+1], m_cfg[idx]};
    end
    if (is_addr(csr)) begin
      idx = int'(csr - CSR_PMPADDR0);
      // NAPOT shows bit 0 as one, OFF and TOR hide bits 1:0
      if (m_cfg[idx][4:3] == 2'b11) begin
        return m_addr[idx] | 32'h0000_0001;
      end
      return m_addr[idx] & 32'hffff_fffc;
    end
    return {29'd0, m_rlb, 1'b0, m_mml};
  endfunction

  function automatic logic [6:0] ref_access(input logic [31:0] addr, input pmp_acc_e acc,
                                            input priv_e priv);
    logic [33:0] a;
    logic [33:0] lo;
    logic [33:0] hi;
    logic [31:0] dc_mask;
    logic [7:0]  c;
    logic        hit;
    logic        found;
    logic        perm;
    logic        allowed;
    logic [5:0]  cause;
    int          ones;
    a     = {2'b00, addr};
    lo    = '0;
    found = 1'b0;
    c     = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      hi   = {m_addr[i], 2'b00};
      ones = 0;
      while (ones < 32 && m_addr[i][ones]) begin
        ones++;
      end
      // Region of 2^(ones+3) bytes
      dc_mask = (ones >= 31) ? 32'hffff_ffff : ((32'd1 << (ones + 1)) - 32'd1);
      case (m_cfg[i][4:3])
        2'b01: hit = (a >= lo) && (a < hi);
        2'b11: hit = ((a[33:2] ^ m_addr[i]) & ~dc_mask) == 32'd0;
        default: hit = 1'b0;
      endcase
      if (hit && !found) begin
        found = 1'b1;
        c     = m_cfg[i];
      end
      lo = hi;
    end
    case (acc)
      PMP_ACC_EXEC: begin
        perm  = c[2];
        cause = 6'd1;
      end
      PMP_ACC_WRITE: begin
        perm  = c[1];
        cause = 6'd7;
      end
      default: begin
        perm  = c[0];
        cause = 6'd5;
      end
    endcase
    if (priv == PRIV_M) begin
      allowed = !found || !c[7] || perm;
    end else begin
      allowed = found && perm;
    end
    return {allowed, cause};
  endfunction

  task automatic apply_write(input logic [11:0] csr, input logic [31:0] data);
    int   idx;
    logic locked_any;
    logic guarded;
    if (is_cfg(csr)) begin
      idx = 4 * int'(csr - CSR_PMPCFG0);
      for (int b = 0; b < 4; b++) begin
        m_cfg[idx+b] = ref_legalize(m_cfg[idx+b], data[8*b +: 8], m_mml, m_rlb);
      end
    end else if (is_addr(csr)) begin
      idx     = int'(csr - CSR_PMPADDR0);
      guarded = m_cfg[idx][7];
      if (idx + 1 < PMP_NUM_REGIONS) begin
        guarded = guarded || (m_cfg[idx+1][7] && m_cfg[idx+1][4:3] == 2'b01);
      end
      if (m_rlb || !guarded) begin
        m_addr[idx] = data;
      end
    end else begin
      locked_any = 1'b0;
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        locked_any = locked_any | m_cfg[i][7];
      end
      m_mml = m_mml | data[0];
      m_rlb = data[2] && (m_rlb || !locked_any);
    end
  endtask

  task automatic apb_access(input logic wr, input logic [11:0] csr, input logic [31:0] wdata,
                            input logic [2:0] prot);
    logic err;
    int   waited;
    err = !prot[0] || !(is_cfg(csr) || is_addr(csr) || csr == CSR_MSECCFG);
    apb_exp_q.push_back({err, (wr || err) ? 32'd0 : ref_read(csr)});
    @(negedge clk_i);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = {18'd0, csr, 2'b00};
    apb_req.pwdata  = wdata;
    apb_req.pprot   = prot;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!apb_rsp.pready && waited < TIMEOUT_CYCLES);
    if (!apb_rsp.pready) begin
      fail_stop("timeout waiting for APB pready");
    end
    if (wr && !err) begin
      apply_write(csr, wdata);
    end
    @(negedge clk_i);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] csr, input logic [31:0] wdata);
    apb_access(1'b1, csr, wdata, 3'b001);
  endtask

  task automatic apb_read(input logic [11:0] csr);
    apb_access(1'b0, csr, 32'd0, 3'b001);
  endtask

  task automatic read_all();
    for (int n = 0; n < PMP_NUM_CFG_REGS; n++) begin
      apb_read(CSR_PMPCFG0 + 12'(n));
    end
    for (int n = 0; n < PMP_NUM_REGIONS; n++) begin
      apb_read(CSR_PMPADDR0 + 12'(n));
    end
    apb_read(CSR_MSECCFG);
  endtask

  task automatic access_req(input logic valid, input logic [31:0] addr, input pmp_acc_e acc,
                            input priv_e priv);
    @(negedge clk_i);
    pmp_req.valid = valid;
    pmp_req.addr  = addr;
    pmp_req.acc   = acc;
    pmp_req.priv  = priv;
    if (valid) begin
      rsp_exp_q.push_back(ref_access(addr, acc, priv));
    end
  endtask

  task automatic drain_responses();
    int waited;
    @(negedge clk_i);
    pmp_req.valid = 1'b0;
    waited = 0;
    while (rsp_exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (rsp_exp_q.size() != 0) begin
      fail_stop("timeout waiting for PMP responses");
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      m_cfg[i]  = '0;
      m_addr[i] = '0;
    end
    m_mml = 1'b0;
    m_rlb = 1'b0;
  endtask

  always @(posedge clk_i) begin : compare
    logic [32:0] apb_exp;
    logic [6:0]  rsp_exp;
    if (!rst_ni) begin
      last_req_valid = 1'b0;
    end else begin
      check_value("pready", apb_rsp.pready, apb_req.psel && apb_req.penable);
      if (apb_rsp.pready) begin
        if (apb_exp_q.size() == 0) begin
          fail_stop("APB response arrived with no access pending");
        end else begin
          apb_exp = apb_exp_q.pop_front();
          check_value("prdata", apb_rsp.prdata, apb_exp[31:0]);
          check_value("pslverr", apb_rsp.pslverr, apb_exp[32]);
        end
      end
      // Response exactly one cycle after its request
      check_value("rsp_valid", pmp_rsp.valid, last_req_valid);
      if (pmp_rsp.valid) begin
        if (rsp_exp_q.size() == 0) begin
          fail_stop("PMP response arrived with no request pending");
        end else begin
          rsp_exp = rsp_exp_q.pop_front();
          check_value("rsp_allowed", pmp_rsp.allowed, rsp_exp[6]);
          if (!rsp_exp[6]) begin
            check_value("rsp_cause", pmp_rsp.cause, rsp_exp[5:0]);
          end
        end
      end
      last_req_valid = pmp_req.valid;
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [7:0]  modes [4];
    pmp_acc_e    acc;
    rng_state  = 32'h0d1c8371;
    error_seen = 1'b0;
    rst_ni     = 1'b0;
    apb_req    = '0;
    pmp_req    = '0;
    modes      = '{8'h18, 8'h00, 8'h08, 8'h18};
    apply_reset();

    // Random cfg words with the lock bits cleared
    for (int n = 0; n < 40; n++) begin
      r = next_rand();
      apb_write(CSR_PMPCFG0 + 12'(r[1:0]), next_rand() & 32'h7f7f_7f7f);
      apb_read(CSR_PMPCFG0 + 12'(r[1:0]));
    end

    // pmpaddr view per mode, entry 2 cycles NAPOT, OFF, TOR, NAPOT
    for (int n = 0; n < PMP_NUM_REGIONS; n++) begin
      apb_write(CSR_PMPADDR0 + 12'(n), next_rand());
      apb_read(CSR_PMPADDR0 + 12'(n));
    end
    apb_write(CSR_PMPADDR0 + 12'd2, 32'h0000_1236);
    for (int n = 0; n < 4; n++) begin
      apb_write(CSR_PMPCFG0, {8'h00, modes[n], 16'h0000});
      apb_read(CSR_PMPADDR0 + 12'd2);
    end

    // Locking with and without RLB, entry 5 is a locked TOR
    apply_reset();
    apb_write(CSR_MSECCFG, 32'h0000_0004);
    apb_write(CSR_PMPCFG0 + 12'd1, 32'h0000_8900);
    apb_write(CSR_PMPADDR0 + 12'd4, 32'h0000_0100);
    apb_write(CSR_PMPADDR0 + 12'd5, 32'h0000_0200);
    apb_write(CSR_PMPCFG0 + 12'd1, 32'h0000_8b00);
    read_all();
    apb_write(CSR_MSECCFG, 32'h0000_0000);
    apb_write(CSR_MSECCFG, 32'h0000_0004);
    apb_write(CSR_PMPADDR0 + 12'd4, 32'h0000_0300);
    apb_write(CSR_PMPADDR0 + 12'd5, 32'h0000_0400);
    apb_write(CSR_PMPADDR0 + 12'd6, 32'h0000_0500);
    apb_write(CSR_PMPCFG0 + 12'd1, 32'h0000_0000);
    read_all();

    // MML, first with RLB then without
    apply_reset();
    apb_write(CSR_MSECCFG, 32'h0000_0004);
    apb_write(CSR_MSECCFG, 32'h0000_0005);
    apb_write(CSR_PMPCFG0, 32'h0000_0085);
    apb_write(CSR_MSECCFG, 32'h0000_0001);
    apb_write(CSR_MSECCFG, 32'h0000_0000);
    apb_write(CSR_PMPCFG0 + 12'd2, 32'h0000_8d8a);
    apb_write(CSR_PMPCFG0 + 12'd2, 32'h0002_0000);
    read_all();
    for (int n = 0; n < 20; n++) begin
      r = next_rand();
      apb_write(CSR_PMPCFG0 + 12'd1 + 12'(r[1:0] % 3), next_rand());
    end
    read_all();

    // Rejected accesses
    apb_access(1'b1, CSR_PMPCFG0 + 12'd3, 32'hffff_ffff, 3'b000);
    apb_access(1'b0, CSR_PMPADDR0, 32'd0, 3'b010);
    apb_write(12'h3A4, 32'hffff_ffff);
    apb_write(12'h3C0, 32'hffff_ffff);
    apb_write(12'hF11, 32'hffff_ffff);
    apb_read(12'h123);
    read_all();

    // Random regions and back-to-back access requests
    apply_reset();
    for (int n = 0; n < PMP_NUM_REGIONS; n++) begin
      apb_write(CSR_PMPADDR0 + 12'(n), next_rand() & 32'h0000_0fff);
    end
    for (int n = 0; n < PMP_NUM_CFG_REGS; n++) begin
      apb_write(CSR_PMPCFG0 + 12'(n), next_rand() & 32'h9f9f_9f9f);
    end
    for (int n = 0; n < 300; n++) begin
      r   = next_rand();
      acc = pmp_acc_e'(r[3:0] % 3);
      access_req(r[31] | r[30], next_rand() & 32'h0000_3fff, acc, r[4] ? PRIV_M : PRIV_U);
    end
    drain_responses();

    if (error_seen) begin
      $display(">>> FAIL");
    end else begin
      $display(">>> PASS");
    end
    $finish;
  end

endmodule

// File: pmp_unit.f
common/pmp_pkg.sv
common/csr_map_pkg.sv
pmp_csr/pmp_cfg_legalize.sv
pmp_csr/pmp_csr_apb.sv
pmp_csr/pmp_csr_regs.sv
src/pmp_access_check.sv
src/pmp_unit.sv
tb/pmp_unit_checker.sv
tb/pmp_unit_tb.sv
